/* udp_rs_encode_pkg.sv */
`default_nettype none

package udp_rs_encode_pkg;

    // ******************************************************************
    // Flit and field widths
    // ******************************************************************
    localparam int NOC_DATA_W   = 128;
    localparam int MSG_LEN_W    = 8;
    localparam int IP_ADDR_W    = 32;
    localparam int PORT_NUM_W   = 16;
    localparam int UDP_LENGTH_W = 16;
    localparam int NUM_BLOCKS_W = 4;

    // Field positions, counted in bits down from the flit MSB.
    localparam int HDR_LEN_TOP        = 0;   // Header flit count, 127..120.
    localparam int META_SRC_IP_TOP    = 0;   // 127..96.
    localparam int META_DST_IP_TOP    = 32;  // 95..64.
    localparam int META_SRC_PORT_TOP  = 64;  // 63..48.
    localparam int META_DST_PORT_TOP  = 80;  // 47..32.
    localparam int META_DATA_LEN_TOP  = 96;  // 31..16.
    localparam int REQ_BLOCKS_TOP     = 0;   // Request block count, 127..124.

    // ******************************************************************
    // Reed-Solomon RS(18,16) over GF(2^8)
    // ******************************************************************
    localparam int MAX_BLOCKS  = 8;   // Parity pairs per parity flit.
    localparam int SYM_W       = 8;
    localparam int RS_PAR_SYMS = 2;

    // x^8 + x^4 + x^3 + x^2 + 1.
    localparam logic [SYM_W:0] GF_POLY = 9'h11D;

    // g(x) = (x + 1)(x + alpha) = x^2 + 3x + 2.
    localparam logic [SYM_W-1:0] RS_G1 = 8'd3;
    localparam logic [SYM_W-1:0] RS_G0 = 8'd2;

    // ******************************************************************
    // Input controller states
    // ******************************************************************
    typedef enum logic [1:0] {
        ST_HDR,
        ST_META,
        ST_REQ,
        ST_DATA
    } in_state_e;

endpackage

`default_nettype wire

/* udp_rs_encode_in_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_in_ctrl
    import udp_rs_encode_pkg::*;
(
     input  wire logic  clk
    ,input  wire logic  rst

    ,input  wire logic  in_val
    ,input  wire logic  last_flit

    ,output logic       store_hdr
    ,output logic       store_meta
    ,output logic       store_req
    ,output logic       incr_flits
    ,output logic       msg_done
);

    in_state_e  state_reg;
    in_state_e  state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_HDR;
        end
        else begin
            state_reg <= state_next;
        end
    end

    // One strobe per valid flit, chosen by where we are in the message.
    always_comb begin
        store_hdr  = 1'b0;
        store_meta = 1'b0;
        store_req  = 1'b0;
        incr_flits = 1'b0;
        state_next = state_reg;

        case (state_reg)
            ST_HDR: begin
                if (in_val) begin
                    store_hdr  = 1'b1;
                    state_next = ST_META;
                end
            end
            ST_META: begin
                if (in_val) begin
                    store_meta = 1'b1;
                    state_next = ST_REQ;
                end
            end
            ST_REQ: begin
                if (in_val) begin
                    store_req  = 1'b1;
                    state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (in_val) begin
                    incr_flits = 1'b1;
                    if (last_flit) begin
                        state_next = ST_HDR;  // Message complete.
                    end
                end
            end
            default: begin
                state_next = ST_HDR;
            end
        endcase
    end

    assign msg_done = incr_flits & last_flit;

endmodule

`default_nettype wire

/* udp_rs_encode_in_datap.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_in_datap
    import udp_rs_encode_pkg::*;
#(
     parameter int noc_data_w = 128
)(
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic  [noc_data_w-1:0]    in_data

    ,input  wire logic                      store_hdr
    ,input  wire logic                      store_meta
    ,input  wire logic                      store_req
    ,input  wire logic                      incr_flits

    ,output logic       [MSG_LEN_W-1:0]     msg_len
    ,output logic       [IP_ADDR_W-1:0]     src_ip
    ,output logic       [IP_ADDR_W-1:0]     dst_ip
    ,output logic       [PORT_NUM_W-1:0]    src_port
    ,output logic       [PORT_NUM_W-1:0]    dst_port
    ,output logic       [UDP_LENGTH_W-1:0]  data_len
    ,output logic       [NUM_BLOCKS_W-1:0]  num_blocks
    ,output logic                           last_flit
);

    localparam int MSB = noc_data_w - 1;

    logic   [MSG_LEN_W-1:0]     msg_len_reg;
    logic   [NUM_BLOCKS_W-1:0]  num_blocks_reg;
    logic   [MSG_LEN_W-1:0]     flit_cnt_reg;
    logic   [MSG_LEN_W-1:0]     flit_cnt_next;
    logic   [MSG_LEN_W-1:0]     data_total;

    logic   [IP_ADDR_W-1:0]     src_ip_reg;
    logic   [IP_ADDR_W-1:0]     dst_ip_reg;
    logic   [PORT_NUM_W-1:0]    src_port_reg;
    logic   [PORT_NUM_W-1:0]    dst_port_reg;
    logic   [UDP_LENGTH_W-1:0]  data_len_reg;

    // ******************************************************************
    // Bypassed field values, valid in the cycle they are stored
    // ******************************************************************
    assign msg_len    = store_hdr ? in_data[MSB-HDR_LEN_TOP -: MSG_LEN_W] : msg_len_reg;
    assign num_blocks = store_req ? in_data[MSB-REQ_BLOCKS_TOP -: NUM_BLOCKS_W]
                                  : num_blocks_reg;

    always_comb begin
        if (store_meta) begin
            src_ip   = in_data[MSB-META_SRC_IP_TOP -: IP_ADDR_W];
            dst_ip   = in_data[MSB-META_DST_IP_TOP -: IP_ADDR_W];
            src_port = in_data[MSB-META_SRC_PORT_TOP -: PORT_NUM_W];
            dst_port = in_data[MSB-META_DST_PORT_TOP -: PORT_NUM_W];
            data_len = in_data[MSB-META_DATA_LEN_TOP -: UDP_LENGTH_W];
        end
        else begin
            src_ip   = src_ip_reg;
            dst_ip   = dst_ip_reg;
            src_port = src_port_reg;
            dst_port = dst_port_reg;
            data_len = data_len_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            msg_len_reg    <= '0;
            num_blocks_reg <= '0;
            flit_cnt_reg   <= '0;
        end
        else begin
            msg_len_reg    <= msg_len;
            num_blocks_reg <= num_blocks;
            flit_cnt_reg   <= flit_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        src_ip_reg   <= src_ip;
        dst_ip_reg   <= dst_ip;
        src_port_reg <= src_port;
        dst_port_reg <= dst_port;
        data_len_reg <= data_len;
    end

    // ******************************************************************
    // Data flit counter
    // ******************************************************************
    assign flit_cnt_next = store_hdr  ? '0
                         : incr_flits ? flit_cnt_reg + 1'b1
                         : flit_cnt_reg;

    assign data_total = msg_len_reg - MSG_LEN_W'(3);  // Less header, meta, request.

    // Counter holds flits already seen, so this one is the last.
    assign last_flit = (flit_cnt_reg + 1'b1) == data_total;

endmodule

`default_nettype wire

/* udp_rs_parity_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_rs_parity_gen
    import udp_rs_encode_pkg::*;
#(
     parameter int noc_data_w = 128
)(
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      clear
    ,input  wire logic                      blk_val
    ,input  wire logic  [noc_data_w-1:0]    blk_data

    ,output logic       [noc_data_w-1:0]    parity_flit
);

    localparam int NUM_SYMS = noc_data_w / SYM_W;
    localparam int PAIR_W   = RS_PAR_SYMS * SYM_W;
    localparam int PAR_W    = MAX_BLOCKS * PAIR_W;
    localparam int SLOT_W   = $clog2(MAX_BLOCKS);

    logic   [PAR_W-1:0]     parity_reg;
    logic   [SLOT_W-1:0]    slot_reg;
    logic   [PAIR_W-1:0]    blk_parity;

    function automatic logic [SYM_W-1:0] gf_mul(
        input logic [SYM_W-1:0] a,
        input logic [SYM_W-1:0] b
    );
        logic [SYM_W-1:0] acc;
        logic [SYM_W-1:0] sh;
        acc = '0;
        sh  = a;
        for (int k = 0; k < SYM_W; k++) begin
            if (b[k]) begin
                acc = acc ^ sh;
            end
            // Multiply by alpha, reduce when x^8 falls out.
            sh = sh[SYM_W-1] ? ((sh << 1) ^ GF_POLY[SYM_W-1:0]) : (sh << 1);
        end
        return acc;
    endfunction

    // Two-stage LFSR division by g(x), MSB symbol first.
    function automatic logic [PAIR_W-1:0] rs_parity(input logic [noc_data_w-1:0] blk);
        logic [SYM_W-1:0] r1;
        logic [SYM_W-1:0] r0;
        logic [SYM_W-1:0] fb;
        r1 = '0;
        r0 = '0;
        for (int s = NUM_SYMS - 1; s >= 0; s--) begin
            fb = blk[s*SYM_W +: SYM_W] ^ r1;
            r1 = r0 ^ gf_mul(fb, RS_G1);
            r0 = gf_mul(fb, RS_G0);
        end
        return {r1, r0};  // p1 in the upper byte.
    endfunction

    assign blk_parity = rs_parity(blk_data);

    // ******************************************************************
    // Parity slot register
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            parity_reg <= '0;
            slot_reg   <= '0;
        end
        else if (blk_val) begin
            parity_reg[PAR_W-1 - slot_reg*PAIR_W -: PAIR_W] <= blk_parity;
            slot_reg <= slot_reg + 1'b1;
        end
    end

    // Slots fill the flit from the top; anything below stays zero.
    always_comb begin
        parity_flit = '0;
        parity_flit[noc_data_w-1 -: PAR_W] = parity_reg;
    end

endmodule

`default_nettype wire

/* udp_rs_encode_out_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_out_assemble
    import udp_rs_encode_pkg::*;
#(
     parameter int noc_data_w = 128
)(
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      in_val
    ,input  wire logic  [noc_data_w-1:0]    in_data

    ,input  wire logic                      store_hdr
    ,input  wire logic                      store_meta
    ,input  wire logic                      msg_done

    ,input  wire logic  [MSG_LEN_W-1:0]     msg_len
    ,input  wire logic  [UDP_LENGTH_W-1:0]  data_len
    ,input  wire logic  [NUM_BLOCKS_W-1:0]  num_blocks

    ,input  wire logic  [noc_data_w-1:0]    parity_flit

    ,output logic                           out_val
    ,output logic       [noc_data_w-1:0]    out_data
    ,output logic                           out_last
);

    localparam int MSB = noc_data_w - 1;

    logic   [noc_data_w-1:0]    flit_q;
    logic                       hdr_q;
    logic                       meta_q;
    logic                       pend_q;

    // ******************************************************************
    // Output registers
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            out_val  <= 1'b0;
            out_last <= 1'b0;
            hdr_q    <= 1'b0;
            meta_q   <= 1'b0;
            pend_q   <= 1'b0;
        end
        else begin
            out_val  <= in_val | pend_q;
            out_last <= pend_q;       // Parity flit closes the message.
            hdr_q    <= store_hdr;
            meta_q   <= store_meta;
            pend_q   <= msg_done;
        end
    end

    // Sender stays idle while the parity flit is pending.
    always_ff @(posedge clk) begin
        if (pend_q) begin
            flit_q <= parity_flit;
        end
        else if (in_val) begin
            flit_q <= in_data;
        end
    end

    // ******************************************************************
    // Field rewrite on the registered flit
    // ******************************************************************
    // The block count only arrives with the request flit, which follows
    // the metadata directly, so the length patch is applied one cycle
    // later, as the metadata leaves the register.
    always_comb begin
        out_data = flit_q;
        if (hdr_q) begin
            out_data[MSB-HDR_LEN_TOP -: MSG_LEN_W] = msg_len + 1'b1;  // Extra parity flit.
        end
        if (meta_q) begin
            out_data[MSB-META_DATA_LEN_TOP -: UDP_LENGTH_W] =
                data_len + UDP_LENGTH_W'({num_blocks, 1'b0});  // Two bytes per block.
        end
    end

endmodule

`default_nettype wire

/* udp_rs_encode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_top
    import udp_rs_encode_pkg::*;
#(
     parameter int noc_data_w = NOC_DATA_W
)(
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      in_val
    ,input  wire logic  [noc_data_w-1:0]    in_data

    ,output logic                           out_val
    ,output logic       [noc_data_w-1:0]    out_data
    ,output logic                           out_last
);

    logic                       store_hdr;
    logic                       store_meta;
    logic                       store_req;
    logic                       incr_flits;
    logic                       msg_done;
    logic                       last_flit;

    logic   [MSG_LEN_W-1:0]     msg_len;
    logic   [UDP_LENGTH_W-1:0]  data_len;
    logic   [NUM_BLOCKS_W-1:0]  num_blocks;
    logic   [noc_data_w-1:0]    parity_flit;

    udp_rs_encode_in_ctrl in_ctrl (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_val        (in_val)
        ,.last_flit     (last_flit)
        ,.store_hdr     (store_hdr)
        ,.store_meta    (store_meta)
        ,.store_req     (store_req)
        ,.incr_flits    (incr_flits)
        ,.msg_done      (msg_done)
    );

    // Addresses and ports pass through the data path unchanged.
    udp_rs_encode_in_datap #(
         .noc_data_w    (noc_data_w)
    ) in_datap (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_data       (in_data)
        ,.store_hdr     (store_hdr)
        ,.store_meta    (store_meta)
        ,.store_req     (store_req)
        ,.incr_flits    (incr_flits)
        ,.msg_len       (msg_len)
        ,.src_ip        ()
        ,.dst_ip        ()
        ,.src_port      ()
        ,.dst_port      ()
        ,.data_len      (data_len)
        ,.num_blocks    (num_blocks)
        ,.last_flit     (last_flit)
    );

    udp_rs_parity_gen #(
         .noc_data_w    (noc_data_w)
    ) parity_gen (
         .clk           (clk)
        ,.rst           (rst)
        ,.clear         (store_hdr)     // New message, empty parity flit.
        ,.blk_val       (incr_flits)
        ,.blk_data      (in_data)
        ,.parity_flit   (parity_flit)
    );

    udp_rs_encode_out_assemble #(
         .noc_data_w    (noc_data_w)
    ) out_assemble (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_val        (in_val)
        ,.in_data       (in_data)
        ,.store_hdr     (store_hdr)
        ,.store_meta    (store_meta)
        ,.msg_done      (msg_done)
        ,.msg_len       (msg_len)
        ,.data_len      (data_len)
        ,.num_blocks    (num_blocks)
        ,.parity_flit   (parity_flit)
        ,.out_val       (out_val)
        ,.out_data      (out_data)
        ,.out_last      (out_last)
    );

endmodule

`default_nettype wire

/* tb_udp_rs_encode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_rs_encode;

    localparam int FLIT_W          = 128;
    localparam int NUM_RAND_MSGS   = 30;
    localparam int NUM_MSGS        = NUM_RAND_MSGS + 2;
    localparam int WATCHDOG_CYCLES = NUM_MSGS * 200 + 400;
    localparam logic [8:0] FIELD_POLY = 9'h11D;

    logic               clk;
    logic               rst;
    logic               in_val;
    logic [FLIT_W-1:0]  in_data;
    logic               out_val;
    logic [FLIT_W-1:0]  out_data;
    logic               out_last;

    logic [31:0]        rand_state;
    int                 cyc = 0;

    logic [FLIT_W-1:0]  exp_data_q[$];
    logic               exp_last_q[$];
    int                 exp_cyc_q[$];

    udp_rs_encode_top #(
        .noc_data_w (FLIT_W)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .in_val     (in_val),
        .in_data    (in_data),
        .out_val    (out_val),
        .out_data   (out_data),
        .out_last   (out_last)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;  // Edge count for latency checks.
    end

    // **********************************************************************
    // Reference model
    // **********************************************************************
    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic logic [FLIT_W-1:0] rand_flit();
        logic [FLIT_W-1:0] f;
        for (int i = 0; i < FLIT_W / 32; i++) begin
            f[32*i +: 32] = next_rand();
        end
        return f;
    endfunction

    // Carry-less product, then fold bits 14..8 back with the field polynomial.
    function automatic logic [7:0] gf_mul_ref(input logic [7:0] a, input logic [7:0] b);
        logic [14:0] prod;
        prod = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ (15'(a) << i);
            end
        end
        for (int k = 14; k >= 8; k--) begin
            if (prod[k]) begin
                prod = prod ^ (15'(FIELD_POLY) << (k - 8));
            end
        end
        return prod[7:0];
    endfunction

    // Remainder of m(x)*x^2 over g(x) = x^2 + 3x + 2 by long division.
    function automatic logic [15:0] rs_parity_ref(input logic [FLIT_W-1:0] blk);
        logic [7:0] coef [0:17];
        logic [7:0] q;
        for (int i = 0; i < 16; i++) begin
            coef[i] = blk[FLIT_W-1-8*i -: 8];  // Top byte is the highest power.
        end
        coef[16] = '0;
        coef[17] = '0;
        for (int i = 0; i < 16; i++) begin
            q = coef[i];
            coef[i+1] = coef[i+1] ^ gf_mul_ref(q, 8'd3);
            coef[i+2] = coef[i+2] ^ gf_mul_ref(q, 8'd2);
        end
        return {coef[16], coef[17]};  // p1 then p0.
    endfunction

    function automatic logic [FLIT_W-1:0] expect_header(input logic [FLIT_W-1:0] hdr);
        logic [FLIT_W-1:0] f;
        f = hdr;
        f[127:120] = hdr[127:120] + 8'd1;  // Parity flit joins the message.
        return f;
    endfunction

    function automatic logic [FLIT_W-1:0] expect_meta(input logic [FLIT_W-1:0] meta,
                                                      input int n);
        logic [FLIT_W-1:0] f;
        f = meta;
        f[31:16] = meta[31:16] + 16'(2 * n);
        return f;
    endfunction

    // **********************************************************************
    // Checking
    // **********************************************************************
    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [FLIT_W-1:0] got,
                               input logic [FLIT_W-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        logic [FLIT_W-1:0] exp_data;
        logic              exp_last;
        int                exp_cyc;
        if (!rst) begin
            if (out_val) begin
                if (exp_data_q.size() == 0) begin
                    $display("unexpected output flit at %0t, no flit was pending", $time);
                    stop_with_failure();
                end
                else begin
                    exp_data = exp_data_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    exp_cyc  = exp_cyc_q.pop_front();
                    check_value("out_data", out_data, exp_data);
                    check_value("out_last", out_last, exp_last);
                    check_value("out_val cycle", cyc, exp_cyc);
                end
            end
            else begin
                check_value("out_last", out_last, '0);
            end
        end
    end

    // **********************************************************************
    // Stimulus
    // **********************************************************************
    task automatic send_flit(input logic [FLIT_W-1:0] data, input logic [FLIT_W-1:0] exp);
        @(posedge clk);
        #1;
        in_val  = 1'b1;
        in_data = data;
        exp_data_q.push_back(exp);
        exp_last_q.push_back(1'b0);
        exp_cyc_q.push_back(cyc + 1);  // Out one cycle after it is sampled.
    endtask

    task automatic send_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            in_val  = 1'b0;
            in_data = rand_flit();
        end
    endtask

    task automatic send_message(input int n, input int gap);
        logic [FLIT_W-1:0] hdr;
        logic [FLIT_W-1:0] meta;
        logic [FLIT_W-1:0] req;
        logic [FLIT_W-1:0] blk;
        logic [FLIT_W-1:0] par;
        hdr  = rand_flit();
        meta = rand_flit();
        req  = rand_flit();
        par  = '0;
        hdr[127:120] = 8'(n + 3);  // Header, metadata, request and data.
        req[127:124] = 4'(n);
        send_flit(hdr, expect_header(hdr));
        send_flit(meta, expect_meta(meta, n));
        send_flit(req, req);
        for (int i = 0; i < n; i++) begin
            blk = rand_flit();
            par[127-16*i -: 16] = rs_parity_ref(blk);
            send_flit(blk, blk);
        end
        exp_data_q.push_back(par);
        exp_last_q.push_back(1'b1);
        exp_cyc_q.push_back(cyc + 2);  // One cycle behind the last data flit.
        send_idle(gap);
    endtask

    initial begin : stimulus
        int n;
        int gap;
        rand_state = 32'd66620;
        rst     = 1'b1;
        in_val  = 1'b0;
        in_data = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        send_idle(20);  // Outputs stay quiet.
        send_message(1, 1);
        send_message(8, 1);  // Every parity slot in use.

        for (int m = 0; m < NUM_RAND_MSGS; m++) begin
            n   = 1 + int'(next_rand() % 8);
            gap = (next_rand() % 4 == 0) ? 2 + int'(next_rand() % 3) : 1;
            send_message(n, gap);
        end

        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        send_idle(10);
        $display("all tests passed");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("output stalled: expected flits still pending after %0d cycles",
                 WATCHDOG_CYCLES);
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* udp_rs_encode.f */
udp_rs_encode_pkg.sv
udp_rs_encode_in_ctrl.sv
udp_rs_encode_in_datap.sv
udp_rs_parity_gen.sv
udp_rs_encode_out_assemble.sv
udp_rs_encode_top.sv
tb_udp_rs_encode.sv
